// File: Makefile
# Verilator build and run of the local-bus slave testbench
VERILATOR  ?= verilator
TOP        := tb_lb_slave
RTL_TOP    := lb_slave_top
FILELIST   := list.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Test FAILED
PASS_MSG   := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without passing"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
verilog/lb_pkg.sv
verilog/lb_decode.sv
verilog/lb_status_counters.sv
verilog/lb_control_regs.sv
verilog/lb_read_mux.sv
verilog/lb_slave_top.sv
testbench/lb_slave_asserts.sv
testbench/tb_lb_slave.sv

// File: testbench/lb_slave_asserts.sv
/*
 * Bound checks on the local-bus slave
 * Read latency, read-valid origin and LED output sanity
 */
module lb_slave_asserts (
	input logic clk,
	input logic rst_n,
	input logic lb_strobe,
	input logic lb_rd,
	input logic lb_rvalid,
	input logic led1,
	input logic led2
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions so far, watched by the testbench
	int assert_failures = 0;

	logic rd_req;

	assign rd_req = lb_strobe & lb_rd;

	// ----------------------------------------
	// Each read request answers two edges later
	read_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rd_req, 2) |-> lb_rvalid)
	else begin
		$error("read valid missing two cycles after a read request");
		assert_failures++;
	end

	// No valid without its request
	rvalid_origin: assert property (@(posedge clk) disable iff (!rst_n)
		lb_rvalid |-> $past(rd_req, 2))
	else begin
		$error("read valid without a read request two cycles earlier");
		assert_failures++;
	end

	led_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({led1, led2}))
	else begin
		$error("LED output unknown after reset");
		assert_failures++;
	end

endmodule

bind lb_slave_top lb_slave_asserts lb_slave_asserts_i (
	.clk(clk), .rst_n(rst_n), .lb_strobe(lb_strobe), .lb_rd(lb_rd),
	.lb_rvalid(lb_rvalid), .led1(led1), .led2(led2)
);

// File: testbench/tb_lb_slave.sv
/*
 * Testbench for the local-bus register slave
 * Clock and reset, LFSR stimulus, reference model with an
 * expected-read queue, value checks and a watchdog
 */
module tb_lb_slave;
	timeunit 1ns;
	timeprecision 1ps;
	import lb_pkg::*;

	// ----------------------------------------
	// Run geometry
	localparam int clk_period = 40;
	localparam int reset_cycles = 8;
	localparam int pwm_width = 10;
	localparam int pwm_period = 2**pwm_width;
	localparam int mirror_aw = 5;
	localparam logic [7:0] misc_default = 8'h00;
	localparam logic [15:0] lfsr_seed = 16'd40;
	localparam int n_ctrl_writes = 24;
	localparam int n_mirror_ops = 64;
	localparam int n_event_cycles = 200;
	localparam int n_mixed_reads = 40;
	localparam int planned_cycles = reset_cycles + 36 + n_ctrl_writes * 4 + 32
		+ n_mirror_ops * 2 + n_event_cycles + 20 + 2 * pwm_period + 16 + n_mixed_reads + 8;

	// Identification text with its first character in the top byte of word 0
	localparam logic [127:0] ident_text = "Hello world!(::)";

	typedef struct packed {
		logic fault;
		logic stb;
		logic [3:0] category;
	} event_t;

	// One queued read result and its allowed distance
	typedef struct packed {
		logic [31:0] value;
		logic [7:0] tol;
	} exp_t;

	localparam event_t no_events = '0;

	logic clk;
	logic rst_n;
	logic lb_strobe;
	logic lb_rd;
	logic [lb_addr_w-1:0] lb_addr;
	logic [lb_data_w-1:0] lb_wdata;
	logic xdomain_fault;
	logic event_stb;
	logic [3:0] event_category;
	logic [lb_data_w-1:0] lb_rdata;
	logic lb_rvalid;
	logic [1:0] led_user_mode;
	logic led1;
	logic led2;
	logic [7:0] misc_config;

	// Reference model state
	logic [31:0] model_mirror [2**mirror_aw];
	logic [19:0] model_cat [16];
	logic [15:0] model_fault;
	logic [1:0] model_led_mode;
	logic [7:0] model_led1_df;
	logic [7:0] model_led2_df;
	logic [7:0] model_misc;
	int cycle_count;
	exp_t exp_q[$];
	logic [15:0] lfsr_state;

	lb_slave_top #(
		.pwm_width(pwm_width), .mirror_aw(mirror_aw), .misc_config_default(misc_default)
	) lb_slave_top_i (
		.clk(clk), .rst_n(rst_n), .lb_strobe(lb_strobe), .lb_rd(lb_rd),
		.lb_addr(lb_addr), .lb_wdata(lb_wdata), .xdomain_fault(xdomain_fault),
		.event_stb(event_stb), .event_category(event_category),
		.lb_rdata(lb_rdata), .lb_rvalid(lb_rvalid), .led_user_mode(led_user_mode),
		.led1(led1), .led2(led2), .misc_config(misc_config)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ----------------------------------------
	// Failure handling and value checks
	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected, input int tol);
		logic [31:0] diff;
		if (actual >= expected) begin
			diff = actual - expected;
		end else begin
			diff = expected - actual;
		end
		if ($isunknown(actual) || diff > 32'(tol)) begin
			$display("mismatch %s: got %h expected %h", name, actual, expected);
			abort_run();
		end
	endtask

	// Taps of x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr_step()};
		end
		return value;
	endfunction

	// ----------------------------------------
	// Request builders leave unused address bits random
	function automatic lb_req_t read_op(input logic [23:0] addr);
		lb_req_t op;
		op.strobe = 1'b1;
		op.rd = 1'b1;
		op.addr = addr;
		op.wdata = '0;
		return op;
	endfunction

	function automatic lb_req_t write_op(input logic [23:0] addr, input logic [31:0] data);
		lb_req_t op;
		op.strobe = 1'b1;
		op.rd = 1'b0;
		op.addr = addr;
		op.wdata = data;
		return op;
	endfunction

	function automatic lb_req_t idle_op();
		return '0;
	endfunction

	function automatic logic [23:0] bank0_addr(input logic [3:0] idx);
		return {page_regs, 11'(rand_bits(11)), 1'b0, idx};
	endfunction

	function automatic logic [23:0] bank1_addr(input logic [3:0] idx);
		return {page_regs, 11'(rand_bits(11)), 1'b1, idx};
	endfunction

	function automatic logic [23:0] local_addr(input logic [4:0] idx);
		return {page_local, 11'(rand_bits(11)), idx};
	endfunction

	// ----------------------------------------
	// Reference model
	function automatic exp_t expect_read(input logic [23:0] addr);
		exp_t e;
		e.tol = 8'd0;
		e.value = unmapped_value;
		if (addr[23:16] == page_regs && !addr[4]) begin
			case (addr[3:0])
				4'd0, 4'd1, 4'd2, 4'd3: e.value = ident_text[127 - 32 * int'(addr[1:0]) -: 32];
				4'd4: e.value = 32'(model_fault);
				4'd5: begin
					// Uptime only needs to sit within one tick of the cycle count
					e.value = 32'(cycle_count / pwm_period);
					e.tol = 8'd1;
				end
				4'd6: e.value = 32'(model_misc);
				4'd7: e.value = {16'h0000, model_led2_df, model_led1_df};
				default: e.value = '0;
			endcase
		end else if (addr[23:16] == page_regs) begin
			e.value = 32'(model_cat[addr[3:0]]);
		end else if (addr[23:16] == page_local) begin
			e.value = model_mirror[addr[mirror_aw-1:0]];
		end
		return e;
	endfunction

	task automatic apply_write(input logic [23:0] addr, input logic [31:0] data);
		if (addr[23:16] == page_local) begin
			model_mirror[addr[mirror_aw-1:0]] = data;
			case (addr[4:0])
				wr_led_user: model_led_mode = data[1:0];
				wr_led1_df: model_led1_df = data[7:0];
				wr_led2_df: model_led2_df = data[7:0];
				wr_misc: model_misc = data[7:0];
				default: ;
			endcase
		end
	endtask

	// Drive one cycle at the falling edge and update the model to match the next edge
	task automatic run_cycle(input lb_req_t op, input event_t ev);
		lb_strobe = op.strobe;
		lb_rd = op.rd;
		lb_addr = op.addr;
		lb_wdata = op.wdata;
		xdomain_fault = ev.fault;
		event_stb = ev.stb;
		event_category = ev.category;
		if (op.strobe && op.rd) begin
			exp_q.push_back(expect_read(op.addr));
		end
		if (op.strobe && !op.rd) begin
			apply_write(op.addr, op.wdata);
		end
		if (ev.fault) begin
			model_fault = model_fault + 16'd1;
		end
		if (ev.stb) begin
			model_cat[ev.category] = model_cat[ev.category] + 20'd1;
		end
		cycle_count++;
		@(negedge clk);
	endtask

	// ----------------------------------------
	// Test phases
	task automatic check_after_reset();
		check_value("misc_config", 32'(misc_config), 32'(misc_default), 0);
		check_value("led_user_mode", 32'(led_user_mode), 32'd0, 0);
		for (int i = 0; i < 16; i++) begin
			run_cycle(read_op(bank0_addr(4'(i))), no_events);
		end
		for (int i = 0; i < 16; i++) begin
			run_cycle(read_op(bank1_addr(4'(i))), no_events);
		end
	endtask

	task automatic exercise_control_writes();
		logic [4:0] idx;
		repeat (n_ctrl_writes) begin
			case (rand_bits(2))
				32'd0: idx = wr_led_user;
				32'd1: idx = wr_led1_df;
				32'd2: idx = wr_led2_df;
				default: idx = wr_misc;
			endcase
			run_cycle(write_op(local_addr(idx), rand_bits(32)), no_events);
			// Outputs follow one edge after the write
			check_value("led_user_mode", 32'(led_user_mode), 32'(model_led_mode), 0);
			check_value("misc_config", 32'(misc_config), 32'(model_misc), 0);
			run_cycle(read_op(bank0_addr(4'd6)), no_events);
			run_cycle(read_op(bank0_addr(4'd7)), no_events);
		end
	endtask

	task automatic exercise_mirror();
		logic [15:0] offset;
		logic [31:0] data;
		logic [1:0] sel;
		// Fill every word once with random high offset bits
		for (int i = 0; i < 2**mirror_aw; i++) begin
			offset = 16'(rand_bits(16));
			offset[mirror_aw-1:0] = mirror_aw'(i);
			run_cycle(write_op({page_local, offset}, rand_bits(32)), no_events);
		end
		repeat (n_mirror_ops) begin
			sel = 2'(rand_bits(2));
			offset = 16'(rand_bits(16));
			data = rand_bits(32);
			if (sel == 2'd0) begin
				run_cycle(write_op({page_local, offset}, data), no_events);
			end else if (sel == 2'd1) begin
				// Read straight after the write
				run_cycle(write_op({page_local, offset}, data), no_events);
				run_cycle(read_op({page_local, offset}), no_events);
			end else begin
				run_cycle(read_op({page_local, offset}), no_events);
			end
		end
	endtask

	task automatic exercise_events();
		event_t ev;
		repeat (n_event_cycles) begin
			ev.fault = 1'(rand_bits(1));
			ev.stb = 1'(rand_bits(1));
			ev.category = 4'(rand_bits(4));
			case (rand_bits(2))
				32'd0: run_cycle(read_op(bank0_addr(4'd4)), ev);
				32'd1: run_cycle(read_op(bank1_addr(4'(rand_bits(4)))), ev);
				32'd2: run_cycle(read_op(bank1_addr(ev.category)), ev);
				default: run_cycle(idle_op(), ev);
			endcase
		end
		// Final tallies with the event inputs quiet
		run_cycle(read_op(bank0_addr(4'd4)), no_events);
		for (int i = 0; i < 16; i++) begin
			run_cycle(read_op(bank1_addr(4'(i))), no_events);
		end
	endtask

	task automatic check_led_pwm();
		logic [7:0] df1;
		logic [7:0] df2;
		int high1;
		int high2;
		df1 = 8'(rand_bits(8));
		df2 = 8'(rand_bits(8));
		run_cycle(write_op(local_addr(wr_led1_df), {24'(rand_bits(24)), df1}), no_events);
		run_cycle(write_op(local_addr(wr_led2_df), {24'(rand_bits(24)), df2}), no_events);
		repeat (8) run_cycle(idle_op(), no_events);
		// Two back-to-back windows of one PWM period from an arbitrary phase
		repeat (2) begin
			high1 = 0;
			high2 = 0;
			repeat (pwm_period) begin
				high1 += int'(led1);
				high2 += int'(led2);
				run_cycle(idle_op(), no_events);
			end
			check_value("led1_high_cycles", 32'(high1), 32'(df1) * 32'd4, 0);
			check_value("led2_high_cycles", 32'(high2), 32'(df2) * 32'd4, 0);
		end
		// Uptime has ticked at least twice by now
		run_cycle(read_op(bank0_addr(4'd5)), no_events);
		run_cycle(read_op(bank0_addr(4'd7)), no_events);
	endtask

	task automatic exercise_unmapped();
		logic [7:0] page;
		repeat (n_mixed_reads) begin
			page = 8'(rand_bits(8));
			while (page == page_regs || page == page_local) begin
				page = 8'(rand_bits(8));
			end
			case (rand_bits(2))
				32'd2: run_cycle(read_op(bank0_addr(4'(rand_bits(4)))), no_events);
				32'd3: run_cycle(read_op({page_local, 16'(rand_bits(16))}), no_events);
				default: run_cycle(read_op({page, 16'(rand_bits(16))}), no_events);
			endcase
		end
	endtask

	// ----------------------------------------
	// Read results are checked on the falling edge where outputs are stable
	initial begin
		exp_t e;
		forever begin
			@(negedge clk);
			if (lb_slave_top_i.lb_slave_asserts_i.assert_failures != 0) begin
				$display("a bound assertion on the DUT failed");
				abort_run();
			end else if (lb_rvalid) begin
				if (exp_q.size() == 0) begin
					$display("read data returned with no read outstanding");
					abort_run();
				end else begin
					e = exp_q.pop_front();
					check_value("lb_rdata", lb_rdata, e.value, int'(e.tol));
				end
			end
		end
	end

	initial begin
		#(4 * planned_cycles * clk_period);
		$display("watchdog expired before the test sequence finished");
		abort_run();
	end

	initial begin
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		lb_addr = '0;
		lb_wdata = '0;
		xdomain_fault = 1'b0;
		event_stb = 1'b0;
		event_category = '0;
		rst_n = 1'b0;
		lfsr_state = lfsr_seed;
		model_fault = '0;
		model_led_mode = '0;
		model_led1_df = '0;
		model_led2_df = '0;
		model_misc = misc_default;
		for (int i = 0; i < 16; i++) begin
			model_cat[i] = '0;
		end
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		cycle_count = 0;
		check_after_reset();
		exercise_control_writes();
		exercise_mirror();
		exercise_events();
		check_led_pwm();
		exercise_unmapped();
		// Let the last reads come back
		repeat (4) run_cycle(idle_op(), no_events);
		if (exp_q.size() == 0 && lb_slave_top_i.lb_slave_asserts_i.assert_failures == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("read results missing or a bound assertion failed at the end of the run");
			abort_run();
		end
	end

endmodule

// File: verilog/lb_control_regs.sv
/*
 * Control registers and mirror memory
 * Direct writes, 32-bit mirror RAM, LED PWM with
 * uptime tick, and the bank-0 read register
 */
module lb_control_regs #(
	parameter int pwm_width = 10,
	parameter int mirror_aw = 5,
	parameter logic [7:0] misc_config_default = 8'h00
) (
	input logic clk,
	input logic rst_n,
	input lb_pkg::lb_cmd_t cmd,
	input logic [15:0] fault_count,
	input logic [31:0] uptime,
	output logic [lb_pkg::lb_data_w-1:0] bank0_data,
	output logic [lb_pkg::lb_data_w-1:0] mirror_data,
	output logic uptime_tick,
	output logic [1:0] led_user_mode,
	output logic led1,
	output logic led2,
	output logic [7:0] misc_config
);
	import lb_pkg::*;

	// Duty factors, 8 bits each
	logic [7:0] led1_df;
	logic [7:0] led2_df;

	// Mirror of every page-5 write
	logic [lb_data_w-1:0] mirror_mem [2**mirror_aw];
	logic [mirror_aw-1:0] mirror_addr;

	// Free-running PWM phase
	logic [pwm_width-1:0] pwm_cnt;

	// Offset wraps modulo mirror depth
	assign mirror_addr = cmd.mirror_offset[mirror_aw-1:0];

	// ----------------------------------------
	// Direct writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_user_mode <= '0;
			led1_df <= '0;
			led2_df <= '0;
			misc_config <= misc_config_default;
		end else if (cmd.wr_local) begin
			case (cmd.wr_index)
				wr_led_user: led_user_mode <= cmd.wdata[1:0];
				wr_led1_df: led1_df <= cmd.wdata[7:0];
				wr_led2_df: led2_df <= cmd.wdata[7:0];
				wr_misc: misc_config <= cmd.wdata[7:0];
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Mirror RAM and bank-0 first read stage
	always_ff @(posedge clk) begin
		// Every local write lands here as well
		if (cmd.wr_local) begin
			mirror_mem[mirror_addr] <= cmd.wdata;
		end
		if (cmd.rd_mirror) begin
			mirror_data <= mirror_mem[mirror_addr];
		end
		if (cmd.rd_bank0) begin
			case (cmd.reg_index)
				4'd0, 4'd1, 4'd2, 4'd3: bank0_data <= ident_words[cmd.reg_index[1:0]];
				rd_fault: bank0_data <= {16'h0000, fault_count};
				rd_uptime: bank0_data <= uptime;
				rd_misc: bank0_data <= {24'h000000, misc_config};
				// led2 high byte, led1 low byte
				rd_duty: bank0_data <= {16'h0000, led2_df, led1_df};
				default: bank0_data <= '0;
			endcase
		end
	end

	// ----------------------------------------
	// LED PWM
	// Carry out of the phase counter is the uptime tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pwm_cnt <= '0;
			uptime_tick <= 1'b0;
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			{uptime_tick, pwm_cnt} <= pwm_cnt + 1'b1;
			// High for 4x duty counts of each period
			led1 <= pwm_cnt < {led1_df, 2'b00};
			led2 <= pwm_cnt < {led2_df, 2'b00};
		end
	end

endmodule

// File: verilog/lb_decode.sv
/*
 * Local-bus request decoder
 * Turns one request into the one-hot command used by
 * the execute and result stages, purely combinational
 */
module lb_decode (
	input lb_pkg::lb_req_t req,
	output lb_pkg::lb_cmd_t cmd
);
	import lb_pkg::*;

	// Request qualifiers
	logic is_rd;
	logic is_wr;

	// Page hits, taken from the register view
	logic hit_regs;
	logic hit_local;

	assign is_rd = req.strobe & req.rd;
	assign is_wr = req.strobe & ~req.rd;

	assign hit_regs = (req.addr.regs.page == page_regs);
	assign hit_local = (req.addr.mirror.page == page_local);

	// ----------------------------------------
	// Read flags
	always_comb begin
		cmd.rd_bank0 = 1'b0;
		cmd.rd_bank1 = 1'b0;
		cmd.rd_mirror = 1'b0;
		cmd.rd_unmapped = 1'b0;
		if (is_rd) begin
			if (hit_regs) begin
				// Bank bit splits page 0 into two 16-word banks
				cmd.rd_bank0 = ~req.addr.regs.bank;
				cmd.rd_bank1 = req.addr.regs.bank;
			end else if (hit_local) begin
				cmd.rd_mirror = 1'b1;
			end else begin
				// Anything else answers with the filler word
				cmd.rd_unmapped = 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Write flag and fields
	// Direct writes only land on page 5
	assign cmd.wr_local = is_wr & hit_local;

	// Control register index is the low offset bits
	assign cmd.wr_index = req.addr.mirror.offset[4:0];

	// Register view index for bank reads
	assign cmd.reg_index = req.addr.regs.idx;

	// Full word offset, the mirror trims it to its own depth
	assign cmd.mirror_offset = req.addr.mirror.offset;

	assign cmd.wdata = req.wdata;

endmodule

// File: verilog/lb_pkg.sv
/*
 * Local-bus slave shared definitions
 * Address layout union, request and command structs,
 * read-map constants and identification words
 */
package lb_pkg;

	// ----------------------------------------
	// Bus geometry
	localparam int lb_addr_w = 24;
	localparam int lb_data_w = 32;

	// Upper address byte picks the page
	typedef logic [7:0] lb_page_t;

	// Register view, page 0 holds two banks of 16 words
	typedef struct packed {
		lb_page_t page;
		logic [10:0] unused;
		logic bank;
		logic [3:0] idx;
	} lb_reg_view_t;

	// Mirror view, page 5 is a flat word space
	typedef struct packed {
		lb_page_t page;
		logic [15:0] offset;
	} lb_mirror_view_t;

	// Same 24 address bits, decoded either way
	typedef union packed {
		lb_reg_view_t regs;
		lb_mirror_view_t mirror;
	} lb_addr_u;

	// Raw bus request as sampled from the pins
	typedef struct packed {
		logic strobe;
		logic rd;
		lb_addr_u addr;
		logic [lb_data_w-1:0] wdata;
	} lb_req_t;

	// Decoded command, flags are one-hot or all clear
	typedef struct packed {
		logic rd_bank0;
		logic rd_bank1;
		logic rd_mirror;
		logic rd_unmapped;
		logic wr_local;
		logic [4:0] wr_index;
		logic [3:0] reg_index;
		logic [15:0] mirror_offset;
		logic [lb_data_w-1:0] wdata;
	} lb_cmd_t;

	// ----------------------------------------
	// Address map
	localparam lb_page_t page_regs = 8'h00;
	localparam lb_page_t page_local = 8'h05;
	localparam logic [lb_data_w-1:0] unmapped_value = 32'hdeadbeef;

	// "Hello world!(::)", word 0 first
	localparam logic [3:0][lb_data_w-1:0] ident_words = {"(::)", "rld!", "o wo", "Hell"};

	// Bank-0 register indices past the identification words
	localparam logic [3:0] rd_fault = 4'd4;
	localparam logic [3:0] rd_uptime = 4'd5;
	localparam logic [3:0] rd_misc = 4'd6;
	localparam logic [3:0] rd_duty = 4'd7;

	// Direct write indices on page 5
	localparam logic [4:0] wr_led_user = 5'd1;
	localparam logic [4:0] wr_led1_df = 5'd2;
	localparam logic [4:0] wr_led2_df = 5'd3;
	localparam logic [4:0] wr_misc = 5'd8;

	// Per-category event statistics
	localparam int num_categories = 16;
	localparam int cat_count_w = 20;

endpackage

// File: verilog/lb_read_mux.sv
/*
 * Second read stage
 * Picks the page result for the delayed read flags and
 * pulses the read-valid flag
 */
module lb_read_mux (
	input logic clk,
	input logic rst_n,
	input lb_pkg::lb_cmd_t cmd,
	input logic [lb_pkg::lb_data_w-1:0] bank0_data,
	input logic [lb_pkg::lb_data_w-1:0] bank1_data,
	input logic [lb_pkg::lb_data_w-1:0] mirror_data,
	output logic [lb_pkg::lb_data_w-1:0] lb_rdata,
	output logic lb_rvalid
);
	import lb_pkg::*;

	// Read flags, one cycle behind the request
	logic rd_bank0_q;
	logic rd_bank1_q;
	logic rd_mirror_q;
	logic rd_unmapped_q;

	// Any read in the first stage
	logic rd_any_q;

	// Page result before the output register
	logic [lb_data_w-1:0] rd_sel;

	// ----------------------------------------
	// Flag delay, aligns with the first-stage data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_bank0_q <= 1'b0;
			rd_bank1_q <= 1'b0;
			rd_mirror_q <= 1'b0;
			rd_unmapped_q <= 1'b0;
		end else begin
			rd_bank0_q <= cmd.rd_bank0;
			rd_bank1_q <= cmd.rd_bank1;
			rd_mirror_q <= cmd.rd_mirror;
			rd_unmapped_q <= cmd.rd_unmapped;
		end
	end

	assign rd_any_q = rd_bank0_q | rd_bank1_q | rd_mirror_q | rd_unmapped_q;

	// Flags are one-hot, unmapped pages fall through
	always_comb begin
		if (rd_bank0_q) begin
			rd_sel = bank0_data;
		end else if (rd_bank1_q) begin
			rd_sel = bank1_data;
		end else if (rd_mirror_q) begin
			rd_sel = mirror_data;
		end else begin
			rd_sel = unmapped_value;
		end
	end

	// ----------------------------------------
	// Output register, data held between reads
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lb_rdata <= '0;
			lb_rvalid <= 1'b0;
		end else begin
			lb_rvalid <= rd_any_q;
			if (rd_any_q) begin
				lb_rdata <= rd_sel;
			end
		end
	end

endmodule

// File: verilog/lb_slave_top.sv
/*
 * Local-bus register slave top level
 * Request packing, decode, execute and result stages
 */
module lb_slave_top #(
	parameter int pwm_width = 10,
	parameter int mirror_aw = 5,
	parameter logic [7:0] misc_config_default = 8'h00
) (
	input logic clk,
	input logic rst_n,
	input logic lb_strobe,
	input logic lb_rd,
	input logic [lb_pkg::lb_addr_w-1:0] lb_addr,
	input logic [lb_pkg::lb_data_w-1:0] lb_wdata,
	input logic xdomain_fault,
	input logic event_stb,
	input logic [3:0] event_category,
	output logic [lb_pkg::lb_data_w-1:0] lb_rdata,
	output logic lb_rvalid,
	output logic [1:0] led_user_mode,
	output logic led1,
	output logic led2,
	output logic [7:0] misc_config
);
	import lb_pkg::*;

	lb_req_t req;
	lb_cmd_t cmd;

	// Execute stage results
	logic [15:0] fault_count;
	logic [31:0] uptime;
	logic uptime_tick;
	logic [lb_data_w-1:0] bank0_data;
	logic [lb_data_w-1:0] bank1_data;
	logic [lb_data_w-1:0] mirror_data;

	// Bundle the pins into one request
	assign req.strobe = lb_strobe;
	assign req.rd = lb_rd;
	assign req.addr = lb_addr;
	assign req.wdata = lb_wdata;

	lb_decode lb_decode_i (
		.req(req),
		.cmd(cmd)
	);

	lb_status_counters lb_status_counters_i (
		.clk(clk), .rst_n(rst_n), .cmd(cmd),
		.xdomain_fault(xdomain_fault), .event_stb(event_stb),
		.event_category(event_category), .uptime_tick(uptime_tick),
		.fault_count(fault_count), .uptime(uptime), .bank1_data(bank1_data)
	);

	lb_control_regs #(
		.pwm_width(pwm_width), .mirror_aw(mirror_aw),
		.misc_config_default(misc_config_default)
	) lb_control_regs_i (
		.clk(clk), .rst_n(rst_n), .cmd(cmd),
		.fault_count(fault_count), .uptime(uptime),
		.bank0_data(bank0_data), .mirror_data(mirror_data), .uptime_tick(uptime_tick),
		.led_user_mode(led_user_mode), .led1(led1), .led2(led2), .misc_config(misc_config)
	);

	lb_read_mux lb_read_mux_i (
		.clk(clk), .rst_n(rst_n), .cmd(cmd),
		.bank0_data(bank0_data), .bank1_data(bank1_data), .mirror_data(mirror_data),
		.lb_rdata(lb_rdata), .lb_rvalid(lb_rvalid)
	);

endmodule

// File: verilog/lb_status_counters.sv
/*
 * Status counters
 * Cross-domain fault count, uptime, per-category event
 * counters and the bank-1 read register
 */
module lb_status_counters (
	input logic clk,
	input logic rst_n,
	input lb_pkg::lb_cmd_t cmd,
	input logic xdomain_fault,
	input logic event_stb,
	input logic [3:0] event_category,
	input logic uptime_tick,
	output logic [15:0] fault_count,
	output logic [31:0] uptime,
	output logic [lb_pkg::lb_data_w-1:0] bank1_data
);
	import lb_pkg::*;

	// One wrapping counter per event category
	logic [cat_count_w-1:0] cat_count [num_categories];

	// ----------------------------------------
	// Fault and uptime counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_count <= '0;
			uptime <= '0;
		end else begin
			// Expect a burst of faults while clocks come up
			if (xdomain_fault) begin
				fault_count <= fault_count + 16'd1;
			end
			// One step per PWM period
			if (uptime_tick) begin
				uptime <= uptime + 32'd1;
			end
		end
	end

	// ----------------------------------------
	// Event statistics
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_categories; i++) begin
				cat_count[i] <= '0;
			end
		end else if (event_stb) begin
			// Only the strobed category moves, wraps at 2^20
			cat_count[event_category] <= cat_count[event_category] + cat_count_w'(1);
		end
	end

	// ----------------------------------------
	// First read stage for bank 1
	// Counter picked by register index, upper bits zero
	always_ff @(posedge clk) begin
		if (cmd.rd_bank1) begin
			bank1_data <= {{(lb_data_w-cat_count_w){1'b0}}, cat_count[cmd.reg_index]};
		end
	end

endmodule
